// File: arith/ntm_scalar_inverter.sv
// Needs an odd modulus and data_in below it; a start while busy is ignored
`timescale 1ns/1ps

module ntm_scalar_inverter (
  input  logic                    CLK,
  input  logic                    RST,
  input  logic                    start,
  input  ntm_scalar_pkg::scalar_t data_in,
  input  ntm_scalar_pkg::scalar_t modulo_in,
  output logic                    done,
  output logic                    fault,
  output ntm_scalar_pkg::scalar_t data_out
);
  import ntm_scalar_pkg::*;

  localparam int N = $bits(scalar_t);
  localparam scalar_ext_t ONE = scalar_ext_t'(1);

  inv_state_e  state;
  // Invariants x*a = u and y*a = v mod m
  // x and y always stay below m
  scalar_ext_t u;
  scalar_ext_t v;
  scalar_ext_t x;
  scalar_ext_t y;
  scalar_ext_t m_q;
  scalar_ext_t x_half;
  scalar_ext_t y_half;

  ////////////////////
  // Halving mod m
  ////////////////////

  // Odd value gets m added first so the shift is exact
  always_comb begin
    x_half = x[0] ? ((x + m_q) >> 1) : (x >> 1);
    y_half = y[0] ? ((y + m_q) >> 1) : (y >> 1);
  end

  ////////////////////
  // Main FSM
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= INV_IDLE;
      done  <= 1'b0;
      fault <= 1'b0;
    end else begin
      done  <= 1'b0;
      fault <= 1'b0;
      case (state)
        INV_IDLE: begin
          if (start) begin
            u   <= {1'b0, data_in};
            v   <= {1'b0, modulo_in};
            x   <= ONE;
            y   <= '0;
            m_q <= {1'b0, modulo_in};
            // Zero has no inverse, answer right away
            if (data_in == '0) begin
              done     <= 1'b1;
              fault    <= 1'b1;
              data_out <= '0;
            end else begin
              state <= INV_CHECK;
            end
          end
        end
        INV_CHECK: begin
          if (u == '0) begin
            // u and v met at the gcd, which is not one
            done     <= 1'b1;
            fault    <= 1'b1;
            data_out <= '0;
            state    <= INV_IDLE;
          end else if (u == ONE) begin
            done     <= 1'b1;
            data_out <= x[N-1:0];
            state    <= INV_IDLE;
          end else if (v == ONE) begin
            done     <= 1'b1;
            data_out <= y[N-1:0];
            state    <= INV_IDLE;
          end else if (!u[0]) begin
            state <= INV_HALVE_U;
          end else if (!v[0]) begin
            state <= INV_HALVE_V;
          end else begin
            state <= INV_SUB;
          end
        end
        // Keep halving while the next value is still even
        INV_HALVE_U: begin
          u <= u >> 1;
          x <= x_half;
          if (u[1]) begin
            state <= INV_CHECK;
          end
        end
        INV_HALVE_V: begin
          v <= v >> 1;
          y <= y_half;
          if (v[1]) begin
            state <= INV_CHECK;
          end
        end
        INV_SUB: begin
          // Both odd here, larger minus smaller
          if (u >= v) begin
            u <= u - v;
            x <= (x >= y) ? (x - y) : (x + m_q - y);
          end else begin
            v <= v - u;
            y <= (y >= x) ? (y - x) : (y + m_q - x);
          end
          state <= INV_CHECK;
        end
        default: state <= INV_IDLE;
      endcase
    end
  end

endmodule

// File: arith/ntm_scalar_multiplier.sv
// Operands must be below an odd or even modulus; latency is fixed at NTM_DATA_SIZE+1
`timescale 1ns/1ps
`include "ntm_scalar_defines.svh"

module ntm_scalar_multiplier (
  input  logic                    CLK,
  input  logic                    RST,
  input  logic                    start,
  input  ntm_scalar_pkg::scalar_t a,
  input  ntm_scalar_pkg::scalar_t b,
  input  ntm_scalar_pkg::scalar_t modulo_in,
  output logic                    done,
  output ntm_scalar_pkg::scalar_t product
);
  import ntm_scalar_pkg::*;

  localparam int N     = `NTM_DATA_SIZE;
  localparam int CNT_W = $clog2(N + 1);

  logic             busy;
  logic [CNT_W-1:0] bits_left;
  scalar_t          a_q;
  scalar_t          b_q;
  scalar_t          m_q;
  // Accumulator stays below m between steps
  scalar_ext_t      acc;
  scalar_ext_t      dbl;
  scalar_ext_t      dbl_red;
  scalar_ext_t      sum;
  scalar_ext_t      sum_red;

  ////////////////////
  // One shift-add step
  ////////////////////

  always_comb begin
    dbl     = {acc[N-1:0], 1'b0};
    dbl_red = (dbl >= {1'b0, m_q}) ? (dbl - {1'b0, m_q}) : dbl;
    // Current bit of b is the top bit of the shift register
    sum     = b_q[N-1] ? (dbl_red + {1'b0, a_q}) : dbl_red;
    sum_red = (sum >= {1'b0, m_q}) ? (sum - {1'b0, m_q}) : sum;
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy      <= 1'b0;
      bits_left <= '0;
      done      <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start && !busy) begin
        busy      <= 1'b1;
        bits_left <= CNT_W'(N);
      end else if (busy) begin
        bits_left <= bits_left - 1'b1;
        // Last bit this cycle
        if (bits_left == CNT_W'(1)) begin
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (start && !busy) begin
      a_q <= a;
      b_q <= b;
      m_q <= modulo_in;
      acc <= '0;
    end else if (busy) begin
      acc <= sum_red;
      b_q <= b_q << 1;
      if (bits_left == CNT_W'(1)) begin
        product <= sum_red[N-1:0];
      end
    end
  end

endmodule

// File: common/ntm_scalar_defines.svh
// Sizes are fixed at compile time; NTM_DATA_SIZE must hold the largest odd modulus in use
`ifndef NTM_SCALAR_DEFINES_SVH
`define NTM_SCALAR_DEFINES_SVH

////////////////////
// Datapath
////////////////////

// Width of operands, modulus and result
// 16 keeps test vectors short, 512 is the production size
`define NTM_DATA_SIZE 16

////////////////////
// Flow control
////////////////////

// Command buffer entries
// Producer starts with this many command credits
`define NTM_CMD_DEPTH 4

// Result credits held after reset
// Must equal the consumer's buffer capacity
`define NTM_RES_CREDITS 2

`endif

// File: common/ntm_scalar_pkg.sv
// Operands are taken as already reduced below an odd modulus; no type here checks that
`include "ntm_scalar_defines.svh"

package ntm_scalar_pkg;

  ////////////////////
  // Data words
  ////////////////////

  // Operand, modulus and result word
  typedef logic [`NTM_DATA_SIZE-1:0] scalar_t;

  // One guard bit for sums and doubling before reduction
  typedef logic [`NTM_DATA_SIZE:0] scalar_ext_t;

  ////////////////////
  // Command and result
  ////////////////////

  // Codes 5 to 7 are unused
  typedef enum logic [2:0] {
    OP_ADD = 3'd0,
    OP_SUB = 3'd1,
    OP_MUL = 3'd2,
    OP_INV = 3'd3,
    OP_DIV = 3'd4
  } scalar_op_e;

  typedef struct packed {
    scalar_op_e op;
    scalar_t    a;
    scalar_t    b;
    scalar_t    modulo;
  } scalar_cmd_s;

  // Fault set means no inverse exists, data is then zero
  typedef struct packed {
    scalar_t data;
    logic    fault;
  } scalar_res_s;

  ////////////////////
  // FSM states
  ////////////////////

  typedef enum logic [2:0] {
    CTRL_IDLE,
    CTRL_RUN,
    CTRL_INV_DIV,
    CTRL_MUL_DIV,
    CTRL_EMIT
  } ctrl_state_e;

  typedef enum logic [2:0] {
    INV_IDLE,
    INV_CHECK,
    INV_HALVE_U,
    INV_HALVE_V,
    INV_SUB
  } inv_state_e;

endpackage

// File: run.sh
#!/bin/sh
# Build with Verilator, run, then search the log for the failure line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f verilog.f \
  --top-module ntm_scalar_tb > build.log 2>&1 &&
./obj_dir/Vntm_scalar_tb > sim.log 2>&1 ||
{ cat build.log sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }
cat sim.log
grep -q "Checks failed" sim.log && exit 1 || exit 0

// File: sim/ntm_clk_gen.sv
// Fixed 20 ns clock; reset is high from time zero and drops after the third rising edge
`timescale 1ns/1ps

module ntm_clk_gen #(
  parameter int PERIOD_NS  = 20,
  parameter int RST_CYCLES = 3
) (
  output logic CLK,
  output logic RST
);

  // Free-running clock
  initial begin
    CLK = 1'b0;
    forever #(PERIOD_NS / 2) CLK = ~CLK;
  end

  // Reset released on a rising edge, like any other driven input
  initial begin
    RST = 1'b1;
    repeat (RST_CYCLES) @(posedge CLK);
    RST <= 1'b0;
  end

endmodule

// File: sim/ntm_scalar_assert.sv
// Occupancy is rebuilt from writes and pops; only meaningful when bound into the ALU
`timescale 1ns/1ps
`include "ntm_scalar_defines.svh"

module ntm_scalar_assert (
  input logic CLK,
  input logic RST,
  input logic cmd_valid,
  input logic fifo_pop,
  input logic res_valid,
  input logic res_credit,
  input logic inv_start,
  input logic inv_done,
  input logic mul_start,
  input logic mul_done
);

  // Entries held in the command buffer
  int   buf_cnt;
  // Result credits the unit still holds
  int   res_crd;
  logic inv_busy;
  logic mul_busy;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      buf_cnt  <= 0;
      res_crd  <= `NTM_RES_CREDITS;
      inv_busy <= 1'b0;
      mul_busy <= 1'b0;
    end else begin
      buf_cnt <= buf_cnt + (cmd_valid ? 1 : 0) - (fifo_pop ? 1 : 0);
      res_crd <= res_crd + (res_credit ? 1 : 0) - (res_valid ? 1 : 0);
      if (inv_start) begin
        inv_busy <= 1'b1;
      end else if (inv_done) begin
        inv_busy <= 1'b0;
      end
      if (mul_start) begin
        mul_busy <= 1'b1;
      end else if (mul_done) begin
        mul_busy <= 1'b0;
      end
    end
  end

  ////////////////////
  // Flow control
  ////////////////////

  // A write needs a free entry in the real buffer
  a_no_overflow: assert property (@(posedge CLK) disable iff (RST)
    cmd_valid |-> (buf_cnt < `NTM_CMD_DEPTH))
    else $error("command buffer written while full");

  a_res_credit: assert property (@(posedge CLK) disable iff (RST)
    res_valid |-> (res_crd > 0))
    else $error("result emitted without a result credit");

  ////////////////////
  // Start and done pairing
  ////////////////////

  a_inv_start: assert property (@(posedge CLK) disable iff (RST)
    inv_start |-> !inv_busy)
    else $error("inverter started again before done");

  a_inv_done: assert property (@(posedge CLK) disable iff (RST)
    inv_done |-> inv_busy)
    else $error("inverter done without a start");

  a_mul_start: assert property (@(posedge CLK) disable iff (RST)
    mul_start |-> !mul_busy)
    else $error("multiplier started again before done");

  a_mul_done: assert property (@(posedge CLK) disable iff (RST)
    mul_done |-> mul_busy)
    else $error("multiplier done without a start");

endmodule

// File: sim/ntm_scalar_tb.sv
// Table values assume NTM_DATA_SIZE of 16 and need more than NTM_CMD_DEPTH+NTM_RES_CREDITS+1 rows
`timescale 1ns/1ps
`include "ntm_scalar_defines.svh"

module ntm_scalar_tb;
  import ntm_scalar_pkg::*;

  localparam int NUM_ROWS = 18;
  localparam int N        = `NTM_DATA_SIZE;
  // Worst divide with margin: inverse, multiply, emit
  localparam int DIV_LAT  = 8 * N + N + 8;
  localparam int HOLD_WIN = 4 * DIV_LAT;
  localparam int LIMIT    = NUM_ROWS * DIV_LAT * 2 + HOLD_WIN + 50;
  localparam int STALL_AT = `NTM_CMD_DEPTH + `NTM_RES_CREDITS + 1;

  logic        CLK;
  logic        RST;
  logic        cmd_valid;
  scalar_cmd_s cmd;
  logic        cmd_credit;
  logic        res_valid;
  scalar_res_s res;
  logic        res_credit;

  // Stimulus and expected values
  string       row_name [NUM_ROWS];
  scalar_cmd_s row_cmd  [NUM_ROWS];
  scalar_res_s row_exp  [NUM_ROWS];
  int          n_rows = 0;

  // Producer and consumer models
  int     prod_credits  = `NTM_CMD_DEPTH;
  int     credit_pulses = 0;
  int     sent          = 0;
  int     recv_cnt      = 0;
  int     owed          = 0;
  logic   send_en       = 1'b0;
  logic   hold          = 1'b1;
  integer seed          = 32'h6aa5_b89d;
  int     errors        = 0;
  int     passes        = 0;

  ntm_clk_gen i_clk (
    .CLK (CLK),
    .RST (RST)
  );

  ntm_scalar_alu i_dut (
    .CLK        (CLK),
    .RST        (RST),
    .cmd_valid  (cmd_valid),
    .cmd        (cmd),
    .cmd_credit (cmd_credit),
    .res_valid  (res_valid),
    .res        (res),
    .res_credit (res_credit)
  );

  bind ntm_scalar_alu ntm_scalar_assert i_assert (
    .CLK        (CLK),
    .RST        (RST),
    .cmd_valid  (cmd_valid),
    .fifo_pop   (fifo_pop),
    .res_valid  (res_valid),
    .res_credit (res_credit),
    .inv_start  (inv_start),
    .inv_done   (inv_done),
    .mul_start  (mul_start),
    .mul_done   (mul_done)
  );

  ////////////////////
  // Test table
  ////////////////////

  task automatic add_row(input string name, input scalar_op_e op, input int a, input int b,
                         input int m, input int data, input logic fault);
    row_name[n_rows] = name;
    row_cmd[n_rows]  = '{op: op, a: scalar_t'(a), b: scalar_t'(b), modulo: scalar_t'(m)};
    row_exp[n_rows]  = '{data: scalar_t'(data), fault: fault};
    n_rows = n_rows + 1;
  endtask

  task automatic load_table();
    // Sums and differences, with wrap
    add_row("add_basic",  OP_ADD, 10,    20,    97,    30,    1'b0);
    add_row("add_wrap",   OP_ADD, 90,    20,    97,    13,    1'b0);
    add_row("add_big",    OP_ADD, 65530, 10,    65535, 5,     1'b0);
    add_row("sub_basic",  OP_SUB, 50,    20,    97,    30,    1'b0);
    add_row("sub_wrap",   OP_SUB, 5,     20,    97,    82,    1'b0);
    // Products, 65535 is the largest odd modulus in 16 bits
    add_row("mul_small",  OP_MUL, 12,    13,    97,    59,    1'b0);
    add_row("mul_wrap",   OP_MUL, 96,    96,    97,    1,     1'b0);
    add_row("mul_max",    OP_MUL, 65534, 65534, 65535, 1,     1'b0);
    add_row("mul_big",    OP_MUL, 1000,  1000,  65521, 17185, 1'b0);
    // Inverses, b unused
    add_row("inv_small",  OP_INV, 3,     0,     97,    65,    1'b0);
    add_row("inv_two",    OP_INV, 2,     0,     97,    49,    1'b0);
    add_row("inv_zero",   OP_INV, 0,     0,     97,    0,     1'b1);
    add_row("inv_shared", OP_INV, 6,     0,     15,    0,     1'b1);
    add_row("inv_max",    OP_INV, 2,     0,     65535, 32768, 1'b0);
    // Quotients a * inv(b)
    add_row("div_basic",  OP_DIV, 10,    3,     97,    68,    1'b0);
    add_row("div_fault",  OP_DIV, 5,     21,    35,    0,     1'b1);
    add_row("div_one",    OP_DIV, 7,     1,     97,    7,     1'b0);
    add_row("div_big",    OP_DIV, 2,     3,     65521, 21841, 1'b0);
  endtask

  ////////////////////
  // Result check
  ////////////////////

  task automatic check_result(input int idx);
    scalar_res_s exp;
    logic        ok;
    longint      prod;
    ok = 1'b1;
    if (idx >= NUM_ROWS) begin
      $display("Result %0d arrived with no command left to match it", idx);
      errors = errors + 1;
      return;
    end
    exp = row_exp[idx];
    if (res.data !== exp.data) begin
      $display("ERR %s data expected %0d actual %0d", row_name[idx], exp.data, res.data);
      ok = 1'b0;
    end
    if (res.fault !== exp.fault) begin
      $display("ERR %s fault expected %0d actual %0d", row_name[idx], exp.fault, res.fault);
      ok = 1'b0;
    end
    // Inverse must also satisfy a*x = 1 mod m
    if (row_cmd[idx].op == OP_INV && !exp.fault) begin
      prod = (longint'(row_cmd[idx].a) * longint'(res.data)) % longint'(row_cmd[idx].modulo);
      if (prod != 1) begin
        $display("ERR %s a*x mod m expected 1 actual %0d", row_name[idx], prod);
        ok = 1'b0;
      end
    end
    if (ok) begin
      $display("ok  %s data %0d fault %0d", row_name[idx], res.data, res.fault);
      passes = passes + 1;
    end else begin
      errors = errors + 1;
    end
  endtask

  ////////////////////
  // Producer
  ////////////////////

  // Spends a credit per command, cmd_credit gives one back
  always @(posedge CLK) begin
    if (RST) begin
      cmd_valid <= 1'b0;
    end else begin
      if (cmd_credit) begin
        prod_credits  = prod_credits + 1;
        credit_pulses = credit_pulses + 1;
      end
      if (send_en && sent < n_rows && prod_credits > 0) begin
        cmd_valid    <= 1'b1;
        cmd          <= row_cmd[sent];
        prod_credits = prod_credits - 1;
        sent         = sent + 1;
      end else begin
        cmd_valid <= 1'b0;
      end
    end
  end

  ////////////////////
  // Consumer
  ////////////////////

  // Returns credits after random gaps unless held
  always @(posedge CLK) begin
    if (RST) begin
      res_credit <= 1'b0;
    end else begin
      res_credit <= 1'b0;
      if (res_valid) begin
        check_result(recv_cnt);
        recv_cnt = recv_cnt + 1;
        owed     = owed + 1;
      end
      if (!hold && owed > 0 && (($random(seed) & 32'h3) != 0)) begin
        res_credit <= 1'b1;
        owed       = owed - 1;
      end
    end
  end

  ////////////////////
  // Sequence
  ////////////////////

  initial begin
    cmd_valid  = 1'b0;
    cmd        = '0;
    res_credit = 1'b0;
    load_table();
    wait (RST == 1'b0);
    @(negedge CLK);
    send_en = 1'b1;
    // Phase one, credits withheld
    wait (recv_cnt == `NTM_RES_CREDITS);
    repeat (HOLD_WIN) @(posedge CLK);
    @(negedge CLK);
    if (recv_cnt != `NTM_RES_CREDITS) begin
      $display("%0d results came out while only %0d result credits were given",
               recv_cnt, `NTM_RES_CREDITS);
      errors = errors + 1;
    end
    if (sent != STALL_AT || prod_credits != 0) begin
      $display("Producer did not stall: %0d sent, %0d credits left, %0d sent expected",
               sent, prod_credits, STALL_AT);
      errors = errors + 1;
    end
    // Phase two, credits flow again
    hold = 1'b0;
    wait (recv_cnt == NUM_ROWS);
    @(negedge CLK);
    if (sent != NUM_ROWS || credit_pulses != sent) begin
      $display("Command credits out of step: %0d sent, %0d credit pulses", sent, credit_pulses);
      errors = errors + 1;
    end
    $display("Rows %0d passed %0d errors %0d", NUM_ROWS, passes, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // Watchdog sized from the row count
  initial begin
    repeat (LIMIT) @(posedge CLK);
    $display("Timeout after %0d cycles with %0d of %0d results received",
             LIMIT, recv_cnt, NUM_ROWS);
    $display("Checks failed");
    $finish;
  end

endmodule

// File: verilog.f
+incdir+common
common/ntm_scalar_pkg.sv
verilog/ntm_cmd_fifo.sv
arith/ntm_scalar_inverter.sv
arith/ntm_scalar_multiplier.sv
verilog/ntm_scalar_controller.sv
verilog/ntm_scalar_alu.sv
sim/ntm_clk_gen.sv
sim/ntm_scalar_assert.sv
sim/ntm_scalar_tb.sv

// File: verilog/ntm_cmd_fifo.sv
// Relies on the producer's credit count to never write when full; pop on empty is ignored
`timescale 1ns/1ps
`include "ntm_scalar_defines.svh"

module ntm_cmd_fifo (
  input  logic                        CLK,
  input  logic                        RST,
  input  logic                        wr_valid,
  input  ntm_scalar_pkg::scalar_cmd_s wr_cmd,
  input  logic                        pop,
  output logic                        not_empty,
  output ntm_scalar_pkg::scalar_cmd_s head,
  output logic                        credit
);
  import ntm_scalar_pkg::*;

  localparam int DEPTH = `NTM_CMD_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  // Storage, no reset needed
  scalar_cmd_s      mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_pop;

  // Head is visible the cycle after its write
  assign not_empty = (count != '0);
  assign head      = mem[rd_ptr];
  assign do_pop    = pop && not_empty;

  always_ff @(posedge CLK) begin
    if (wr_valid) begin
      mem[wr_ptr] <= wr_cmd;
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      credit <= 1'b0;
    end else begin
      // One credit back per entry removed
      credit <= do_pop;
      if (wr_valid) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous write and pop keeps the count
      case ({wr_valid, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: verilog/ntm_scalar_alu.sv
// Producer must honour cmd_credit and consumer must return res_credit; results stay in order
`timescale 1ns/1ps

module ntm_scalar_alu (
  input  logic                        CLK,
  input  logic                        RST,
  input  logic                        cmd_valid,
  input  ntm_scalar_pkg::scalar_cmd_s cmd,
  output logic                        cmd_credit,
  output logic                        res_valid,
  output ntm_scalar_pkg::scalar_res_s res,
  input  logic                        res_credit
);
  import ntm_scalar_pkg::*;

  ////////////////////
  // Internal wiring
  ////////////////////

  // Buffer to controller
  logic        fifo_not_empty;
  logic        fifo_pop;
  scalar_cmd_s fifo_head;

  // Controller to inverter
  logic        inv_start;
  logic        inv_done;
  logic        inv_fault;
  scalar_t     inv_data;
  scalar_t     inv_modulo;
  scalar_t     inv_result;

  // Controller to multiplier
  logic        mul_start;
  logic        mul_done;
  scalar_t     mul_a;
  scalar_t     mul_b;
  scalar_t     mul_modulo;
  scalar_t     mul_result;

  ntm_cmd_fifo i_fifo (
    .CLK       (CLK),
    .RST       (RST),
    .wr_valid  (cmd_valid),
    .wr_cmd    (cmd),
    .pop       (fifo_pop),
    .not_empty (fifo_not_empty),
    .head      (fifo_head),
    .credit    (cmd_credit)
  );

  ntm_scalar_controller i_ctrl (
    .CLK        (CLK),
    .RST        (RST),
    .not_empty  (fifo_not_empty),
    .head       (fifo_head),
    .pop        (fifo_pop),
    .inv_start  (inv_start),
    .inv_data   (inv_data),
    .inv_modulo (inv_modulo),
    .inv_done   (inv_done),
    .inv_fault  (inv_fault),
    .inv_result (inv_result),
    .mul_start  (mul_start),
    .mul_a      (mul_a),
    .mul_b      (mul_b),
    .mul_modulo (mul_modulo),
    .mul_done   (mul_done),
    .mul_result (mul_result),
    .res_credit (res_credit),
    .res_valid  (res_valid),
    .res        (res)
  );

  ntm_scalar_inverter i_inv (
    .CLK       (CLK),
    .RST       (RST),
    .start     (inv_start),
    .data_in   (inv_data),
    .modulo_in (inv_modulo),
    .done      (inv_done),
    .fault     (inv_fault),
    .data_out  (inv_result)
  );

  ntm_scalar_multiplier i_mul (
    .CLK       (CLK),
    .RST       (RST),
    .start     (mul_start),
    .a         (mul_a),
    .b         (mul_b),
    .modulo_in (mul_modulo),
    .done      (mul_done),
    .product   (mul_result)
  );

endmodule

// File: verilog/ntm_scalar_controller.sv
// One command at a time; opcodes 5 to 7 run as add and modulus oddness is not checked
`timescale 1ns/1ps
`include "ntm_scalar_defines.svh"

module ntm_scalar_controller (
  input  logic                        CLK,
  input  logic                        RST,
  input  logic                        not_empty,
  input  ntm_scalar_pkg::scalar_cmd_s head,
  output logic                        pop,
  output logic                        inv_start,
  output ntm_scalar_pkg::scalar_t     inv_data,
  output ntm_scalar_pkg::scalar_t     inv_modulo,
  input  logic                        inv_done,
  input  logic                        inv_fault,
  input  ntm_scalar_pkg::scalar_t     inv_result,
  output logic                        mul_start,
  output ntm_scalar_pkg::scalar_t     mul_a,
  output ntm_scalar_pkg::scalar_t     mul_b,
  output ntm_scalar_pkg::scalar_t     mul_modulo,
  input  logic                        mul_done,
  input  ntm_scalar_pkg::scalar_t     mul_result,
  input  logic                        res_credit,
  output logic                        res_valid,
  output ntm_scalar_pkg::scalar_res_s res
);
  import ntm_scalar_pkg::*;

  localparam int N     = $bits(scalar_t);
  localparam int CRD_W = $clog2(`NTM_RES_CREDITS + 1);

  ctrl_state_e      state;
  scalar_cmd_s      cmd_q;
  scalar_t          mul_b_q;
  scalar_res_s      res_q;
  logic [CRD_W-1:0] credits;
  scalar_ext_t      sum;
  scalar_ext_t      sum_red;
  scalar_t          diff;
  scalar_t          addsub;

  ////////////////////
  // Handshakes
  ////////////////////

  assign pop       = (state == CTRL_IDLE) && not_empty;
  // Finished result waits in emit until a credit is there
  assign res_valid = (state == CTRL_EMIT) && (credits != '0);
  assign res       = res_q;

  // Divide inverts b, plain inverse works on a
  assign inv_data   = (cmd_q.op == OP_DIV) ? cmd_q.b : cmd_q.a;
  assign inv_modulo = cmd_q.modulo;
  assign mul_a      = cmd_q.a;
  assign mul_b      = mul_b_q;
  assign mul_modulo = cmd_q.modulo;

  // Add and subtract with a single correction
  always_comb begin
    sum     = {1'b0, cmd_q.a} + {1'b0, cmd_q.b};
    sum_red = (sum >= {1'b0, cmd_q.modulo}) ? (sum - {1'b0, cmd_q.modulo}) : sum;
    // Wraps mod 2^N, true value lands in range
    diff    = (cmd_q.a >= cmd_q.b) ? (cmd_q.a - cmd_q.b) : (cmd_q.a - cmd_q.b + cmd_q.modulo);
    addsub  = (cmd_q.op == OP_SUB) ? diff : sum_red[N-1:0];
  end

  // Consumer returns, emit spends
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      credits <= CRD_W'(`NTM_RES_CREDITS);
    end else begin
      credits <= credits + CRD_W'(res_credit) - CRD_W'(res_valid);
    end
  end

  ////////////////////
  // Dispatch FSM
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= CTRL_IDLE;
      inv_start <= 1'b0;
      mul_start <= 1'b0;
    end else begin
      inv_start <= 1'b0;
      mul_start <= 1'b0;
      case (state)
        CTRL_IDLE: begin
          if (pop) begin
            cmd_q   <= head;
            mul_b_q <= head.b;
            case (head.op)
              OP_MUL: begin
                mul_start <= 1'b1;
                state     <= CTRL_RUN;
              end
              OP_INV: begin
                inv_start <= 1'b1;
                state     <= CTRL_RUN;
              end
              OP_DIV: begin
                inv_start <= 1'b1;
                state     <= CTRL_INV_DIV;
              end
              default: state <= CTRL_RUN;
            endcase
          end
        end
        CTRL_RUN: begin
          case (cmd_q.op)
            OP_MUL: begin
              if (mul_done) begin
                res_q <= '{data: mul_result, fault: 1'b0};
                state <= CTRL_EMIT;
              end
            end
            OP_INV: begin
              // Inverter already zeroes data on fault
              if (inv_done) begin
                res_q <= '{data: inv_result, fault: inv_fault};
                state <= CTRL_EMIT;
              end
            end
            default: begin
              res_q <= '{data: addsub, fault: 1'b0};
              state <= CTRL_EMIT;
            end
          endcase
        end
        CTRL_INV_DIV: begin
          if (inv_done) begin
            if (inv_fault) begin
              // No inverse of b, skip the multiply
              res_q <= '{data: '0, fault: 1'b1};
              state <= CTRL_EMIT;
            end else begin
              mul_b_q   <= inv_result;
              mul_start <= 1'b1;
              state     <= CTRL_MUL_DIV;
            end
          end
        end
        CTRL_MUL_DIV: begin
          if (mul_done) begin
            res_q <= '{data: mul_result, fault: 1'b0};
            state <= CTRL_EMIT;
          end
        end
        CTRL_EMIT: begin
          if (res_valid) begin
            state <= CTRL_IDLE;
          end
        end
        default: state <= CTRL_IDLE;
      endcase
    end
  end

endmodule
